//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	////////////////////////////// geometry
	localparam int NUM_WAYS = 4; // ways per set.
	localparam int NUM_SETS = 8; // sets, indexed by addr[7:5].
	localparam int WORDS_PER_LINE = 8; // 32-byte line.
	localparam logic [7:0] BURST_LEN = 8'd7; // len field, eight beats.

	////////////////////////////// widths
	typedef logic [23:0] tag_t; // addr[31:8].
	typedef logic [2:0] index_t; // addr[7:5].
	typedef logic [2:0] word_sel_t; // addr[4:2].
	typedef logic [31:0] word_t;
	typedef logic [3:0] strb_t; // one bit per byte.
	typedef logic [255:0] line_t; // word 0 in the low bits.
	typedef logic [NUM_WAYS-1:0] way_mask_t; // one-hot.
	typedef logic [1:0] order_t; // 0 newest, 3 next victim.
	typedef order_t [NUM_WAYS-1:0] set_order_t; // ranks of one set.

	// controller states.
	typedef enum logic [2:0] {
		idle, // waiting for a cpu request.
		evict_req, // write-back request out.
		evict_send, // write-back beats out.
		fill_req, // refill request out.
		fill_recv, // refill beats in.
		fill_write, // refilled line into the way.
		respond // read word held for the cpu.
	} cache_state_t;

	typedef struct packed {
		logic write; // 1 for a store.
		logic [31:0] addr; // word aligned.
		word_t wdata;
		strb_t wstrb;
	} cpu_req_t;

	typedef struct packed {
		logic hit;
		way_mask_t way; // hit way, else the victim.
		logic victim_dirty; // dirty bit of that way.
		tag_t victim_tag; // tag held by the victim way.
		line_t line; // data of the selected way.
	} lookup_t;

endpackage

`default_nettype wire

//--- dcache/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  dcache_pkg::cpu_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output dcache_pkg::word_t rsp_data,
	input  logic rsp_ready,
	output logic rd_req_valid,
	output logic rd_rsp_ready,
	input  logic rd_rsp_valid,
	input  logic rd_rsp_last,
	input  logic rd_req_ready,
	output logic wr_req_valid,
	input  logic wr_req_ready,
	input  logic wr_data_ready,
	output logic wr_data_valid,
	input  logic beat_last,
	output dcache_pkg::index_t index,
	output dcache_pkg::tag_t tag,
	output dcache_pkg::way_mask_t wen,
	output dcache_pkg::line_t wline,
	output logic set_dirty,
	output logic clear_dirty,
	output logic touch,
	input  dcache_pkg::lookup_t result,
	output logic buf_load,
	output logic buf_shift,
	output logic buf_send,
	input  dcache_pkg::line_t buf_line,
	output logic [31:0] rd_req_addr,
	output logic [31:0] wr_req_addr
);
	import dcache_pkg::*;

	cache_state_t state, state_next;
	cpu_req_t req_q; // request held during a miss.
	cpu_req_t cur; // live request in idle, held one otherwise.
	way_mask_t vic_way_q; // way chosen at accept time.
	tag_t vic_tag_q;
	word_t rsp_q;
	word_sel_t sel;
	line_t base_line; // hit line or refilled line.
	logic accept;

	// byte-wise merge of one word into a line.
	function automatic line_t merge_word(line_t line, word_sel_t ws, word_t wdata, strb_t wstrb);
		line_t merged;
		merged = line;
		for (int b = 0; b < 4; b++) begin
			if (wstrb[b])
				merged[int'(ws) * 32 + b * 8 +: 8] = wdata[b * 8 +: 8];
		end
		return merged;
	endfunction

	////////////////////////////// request path
	assign req_ready = (state == idle);
	assign accept = req_valid && req_ready;
	assign cur = (state == idle) ? req : req_q;
	assign tag = cur.addr[31:8];
	assign index = cur.addr[7:5];
	assign sel = cur.addr[4:2];
	assign base_line = (state == idle) ? result.line : buf_line;
	assign touch = accept; // ranks move once per request.

	// reads merge with a zero strobe and keep the line as it is.
	assign wline = merge_word(base_line, sel, cur.wdata, cur.write ? cur.wstrb : 4'b0000);

	always_comb begin
		if (accept && result.hit && req.write)
			wen = result.way; // write hit, same cycle.
		else if (state == fill_write)
			wen = vic_way_q; // refill into the saved victim.
		else
			wen = '0;
	end

	assign set_dirty = (|wen) && cur.write;
	assign clear_dirty = (|wen) && !cur.write;

	////////////////////////////// fsm
	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (req_valid) begin
					if (!result.hit)
						state_next = result.victim_dirty ? evict_req : fill_req;
					else if (!req.write)
						state_next = respond; // write hits stay in idle.
				end
			end
			evict_req: if (wr_req_ready) state_next = evict_send;
			evict_send: if (wr_data_ready && beat_last) state_next = fill_req;
			fill_req: if (rd_req_ready) state_next = fill_recv;
			fill_recv: if (rd_rsp_valid && rd_rsp_last) state_next = fill_write;
			fill_write: state_next = cur.write ? idle : respond;
			respond: if (rsp_ready) state_next = idle;
			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
			vic_way_q <= result.way; // ranks change at this edge.
			vic_tag_q <= result.victim_tag;
		end
		if (state_next == respond && state != respond)
			rsp_q <= base_line[{sel, 5'd0} +: 32]; // read word for the cpu.
	end

	////////////////////////////// outputs
	assign rsp_valid = (state == respond);
	assign rsp_data = rsp_q;
	assign buf_load = accept && !result.hit && result.victim_dirty; // victim line to buffer.
	assign buf_shift = (state == fill_recv) && rd_rsp_valid;
	assign buf_send = (state == evict_send) && wr_data_ready;
	assign rd_req_valid = (state == fill_req);
	assign rd_rsp_ready = (state == fill_recv);
	assign wr_req_valid = (state == evict_req);
	assign wr_data_valid = (state == evict_send);
	assign rd_req_addr = {req_q.addr[31:5], 5'd0}; // line aligned.
	assign wr_req_addr = {vic_tag_q, req_q.addr[7:5], 5'd0};

endmodule

`default_nettype wire

//--- dcache/dcache_line_buffer.sv
`default_nettype none

module dcache_line_buffer (
	input  logic clk,
	input  logic buf_load, // victim line in, counter to beat 0.
	input  dcache_pkg::line_t load_line,
	input  logic buf_shift, // one refill beat.
	input  dcache_pkg::word_t shift_word,
	input  logic buf_send, // one write-back beat accepted.
	output dcache_pkg::line_t line,
	output dcache_pkg::word_t send_word,
	output logic beat_last
);
	import dcache_pkg::*;

	word_sel_t beat_cnt; // word now on the write bus.

	////////////////////////////// data
	always_ff @(posedge clk) begin
		if (buf_load)
			line <= load_line;
		else if (buf_shift)
			line <= {shift_word, line[$bits(line_t) - 1:32]}; // first beat ends in word 0.
	end

	////////////////////////////// beat count
	always_ff @(posedge clk) begin
		if (buf_load)
			beat_cnt <= '0;
		else if (buf_send)
			beat_cnt <= beat_cnt + 3'd1; // wraps after the eighth beat.
	end

	assign send_word = line[{beat_cnt, 5'd0} +: 32];
	assign beat_last = (beat_cnt == word_sel_t'(WORDS_PER_LINE - 1));

endmodule

`default_nettype wire

//--- dcache/dcache_recency.sv
`default_nettype none

module dcache_recency (
	input  logic clk,
	input  logic rst,
	input  dcache_pkg::index_t index,
	input  logic touch, // one per accepted request.
	input  dcache_pkg::way_mask_t way, // one-hot, hit way or victim.
	output dcache_pkg::way_mask_t victim
);
	import dcache_pkg::*;

	set_order_t [NUM_SETS-1:0] order_q; // ranks of all sets.
	set_order_t cur; // ranks of the addressed set.
	set_order_t upd; // ranks after the touch.
	order_t old_rank; // rank of the touched way before the touch.

	assign cur = order_q[index];

	// lowest-numbered way at rank 3 is evicted.
	always_comb begin
		victim = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (cur[w] == 2'd3)
				victim = way_mask_t'(1) << w; // lower ways overwrite higher ones.
		end
	end

	always_comb begin
		old_rank = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way[w])
				old_rank = cur[w];
		end
	end

	////////////////////////////// update
	// touched way becomes newest, ways newer than it age by one.
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way[w])
				upd[w] = 2'd0;
			else if (cur[w] < old_rank)
				upd[w] = cur[w] + 2'd1;
			else
				upd[w] = cur[w]; // older ways keep their rank.
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			order_q <= '1; // every rank starts at 3.
		else if (touch)
			order_q[index] <= upd;
	end

endmodule

`default_nettype wire

//--- dcache/dcache_tag_store.sv
`default_nettype none

module dcache_tag_store (
	input  logic clk,
	input  logic rst,
	input  dcache_pkg::index_t index,
	input  dcache_pkg::tag_t tag,
	input  dcache_pkg::way_mask_t victim, // used when nothing hits.
	input  dcache_pkg::way_mask_t wen,
	input  dcache_pkg::line_t wline,
	input  logic set_dirty, // applies to the ways in wen.
	input  logic clear_dirty,
	output dcache_pkg::lookup_t result
);
	import dcache_pkg::*;

	tag_t tag_mem [NUM_WAYS][NUM_SETS];
	line_t data_mem [NUM_WAYS][NUM_SETS];
	way_mask_t [NUM_SETS-1:0] valid_q; // one bit per way and set.
	way_mask_t [NUM_SETS-1:0] dirty_q;
	way_mask_t hit_vec;

	////////////////////////////// arrays
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (wen[w]) begin
				tag_mem[w][index] <= tag; // tag and line go in together.
				data_mem[w][index] <= wline;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			valid_q[index] <= valid_q[index] | wen; // any write leaves the way valid.
			if (set_dirty)
				dirty_q[index] <= dirty_q[index] | wen; // store data merged.
			else if (clear_dirty)
				dirty_q[index] <= dirty_q[index] & ~wen; // clean refill.
		end
	end

	////////////////////////////// lookup
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++)
			hit_vec[w] = valid_q[index][w] && (tag_mem[w][index] == tag); // parallel compare.
	end

	always_comb begin
		result.hit = |hit_vec;
		result.way = result.hit ? hit_vec : victim; // hit way wins over the victim.
		result.victim_dirty = 1'b0;
		result.victim_tag = '0;
		result.line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (result.way[w]) begin
				result.victim_dirty = dirty_q[index][w];
				result.line = data_mem[w][index];
			end
			if (victim[w])
				result.victim_tag = tag_mem[w][index]; // for the write-back address.
		end
	end

endmodule

`default_nettype wire

//--- dcache/dcache_top.sv
`default_nettype none

module dcache_top (
	input  logic clk,
	input  logic rst,

	////////////////////////////// cpu side
	input  logic req_valid,
	input  dcache_pkg::cpu_req_t req,
	output logic req_ready,
	output logic rsp_valid,
	output dcache_pkg::word_t rsp_data,
	input  logic rsp_ready,

	////////////////////////////// memory read side
	output logic rd_req_valid,
	output logic [31:0] rd_req_addr,
	output logic [7:0] rd_req_len,
	input  logic rd_req_ready,
	input  logic rd_rsp_valid,
	input  dcache_pkg::word_t rd_rsp_data,
	input  logic rd_rsp_last,
	output logic rd_rsp_ready,

	////////////////////////////// memory write side
	output logic wr_req_valid,
	output logic [31:0] wr_req_addr,
	output logic [7:0] wr_req_len,
	input  logic wr_req_ready,
	output logic wr_data_valid,
	output dcache_pkg::word_t wr_data,
	output dcache_pkg::strb_t wr_data_strb,
	output logic wr_data_last,
	input  logic wr_data_ready
);
	import dcache_pkg::*;

	lookup_t result; // tag store to controller.
	way_mask_t victim; // recency choice for the set.
	way_mask_t wen;
	line_t wline;
	line_t buf_line;
	index_t index;
	tag_t tag;
	logic set_dirty;
	logic clear_dirty;
	logic touch;
	logic buf_load;
	logic buf_shift;
	logic buf_send;
	logic beat_last;

	assign rd_req_len = BURST_LEN; // always a full line.
	assign wr_req_len = BURST_LEN;
	assign wr_data_strb = 4'b1111; // write-backs carry whole words.
	assign wr_data_last = wr_data_valid & beat_last; // eighth beat only.

	dcache_tag_store u_tag_store (
		.clk(clk), .rst(rst), .index(index), .tag(tag), .victim(victim),
		.wen(wen), .wline(wline), .set_dirty(set_dirty), .clear_dirty(clear_dirty),
		.result(result)
	);

	dcache_recency u_recency (
		.clk(clk), .rst(rst), .index(index), .touch(touch), .way(result.way),
		.victim(victim)
	);

	dcache_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
		.rd_req_valid(rd_req_valid), .rd_rsp_ready(rd_rsp_ready),
		.rd_rsp_valid(rd_rsp_valid), .rd_rsp_last(rd_rsp_last), .rd_req_ready(rd_req_ready),
		.wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
		.wr_data_ready(wr_data_ready), .wr_data_valid(wr_data_valid), .beat_last(beat_last),
		.index(index), .tag(tag), .wen(wen), .wline(wline),
		.set_dirty(set_dirty), .clear_dirty(clear_dirty), .touch(touch),
		.result(result),
		.buf_load(buf_load), .buf_shift(buf_shift), .buf_send(buf_send), .buf_line(buf_line),
		.rd_req_addr(rd_req_addr), .wr_req_addr(wr_req_addr)
	);

	dcache_line_buffer u_line_buffer (
		.clk(clk), .buf_load(buf_load), .load_line(result.line),
		.buf_shift(buf_shift), .shift_word(rd_rsp_data), .buf_send(buf_send),
		.line(buf_line), .send_word(wr_data), .beat_last(beat_last)
	);

endmodule

`default_nettype wire

//--- filelist.f
common/dcache_pkg.sv
dcache/dcache_tag_store.sv
dcache/dcache_recency.sv
dcache/dcache_ctrl.sv
dcache/dcache_line_buffer.sv
dcache/dcache_top.sv
tests/dcache_monitor.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module dcache_tb -o dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	exit 1
fi
exit 0

//--- tests/dcache_chk.sv
`default_nettype none

module dcache_chk (
	input  logic clk,
	input  logic rst,
	input  logic rsp_valid,
	input  logic rsp_ready,
	input  dcache_pkg::word_t rsp_data,
	input  logic rd_req_valid,
	input  logic rd_req_ready,
	input  logic [31:0] rd_req_addr,
	input  logic wr_req_valid,
	input  logic wr_req_ready,
	input  logic [31:0] wr_req_addr,
	input  logic wr_data_valid,
	input  logic wr_data_ready
);

	////////////////////////////// handshakes
	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
		else $error("read response dropped or changed before rsp_ready");

	a_rd_req_hold: assert property (@(posedge clk) disable iff (rst)
		rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr))
		else $error("refill request dropped or changed before rd_req_ready");

	a_wr_req_hold: assert property (@(posedge clk) disable iff (rst)
		wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req_addr))
		else $error("write-back request dropped or changed before wr_req_ready");

	a_wr_data_hold: assert property (@(posedge clk) disable iff (rst)
		wr_data_valid && !wr_data_ready |=> wr_data_valid)
		else $error("write-back beat dropped before wr_data_ready");

endmodule

bind dcache_top dcache_chk u_chk (
	.clk(clk), .rst(rst),
	.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
	.rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready), .rd_req_addr(rd_req_addr),
	.wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready), .wr_req_addr(wr_req_addr),
	.wr_data_valid(wr_data_valid), .wr_data_ready(wr_data_ready)
);

`default_nettype wire

//--- tests/dcache_monitor.sv
`default_nettype none

module dcache_monitor (
	input  logic clk,
	input  logic rst,
	input  logic drain, // all requests done, check leftovers.
	input  logic req_valid,
	input  logic req_ready,
	input  dcache_pkg::cpu_req_t req,
	input  logic rsp_valid,
	input  logic rsp_ready,
	input  dcache_pkg::word_t rsp_data,
	input  logic rd_req_valid,
	input  logic rd_req_ready,
	input  logic [31:0] rd_req_addr,
	input  logic [7:0] rd_req_len,
	input  logic wr_req_valid,
	input  logic wr_req_ready,
	input  logic [31:0] wr_req_addr,
	input  logic [7:0] wr_req_len,
	input  logic wr_data_valid,
	input  logic wr_data_ready,
	input  dcache_pkg::word_t wr_data,
	input  dcache_pkg::strb_t wr_data_strb,
	input  logic wr_data_last,
	output int err_count
);
	import dcache_pkg::*;

	logic [31:0] pat [320]; // five words per pattern line.
	word_t exp_rd [$]; // read results in issue order.
	logic [31:0] exp_wb [$]; // write-back line addresses.
	word_t ref_mem [1024]; // memory as it reads once every dirty line is back.
	int errors = 0;

	assign err_count = errors;

	task automatic log_mismatch(input string msg);
		errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic raise_error(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	initial begin : watch
		int i;
		int wb_beat;
		int wb_base;
		logic drained;
		word_t exp;
		logic [31:0] exp_addr;
		logic [31:0] line_addr;
		i = 0;
		wb_beat = 0;
		wb_base = 0;
		drained = 1'b0;
		line_addr = '0;
		for (int k = 0; k < 1024; k++)
			ref_mem[k] = k ^ 32'h5a5a0000; // word address mixed with a marker.
		$readmemh("tests/dcache_patterns.txt", pat);
		while (i < 64 && pat[5 * i] != 32'hf) begin
			if (pat[5 * i] == 32'h1)
				exp_rd.push_back(pat[5 * i + 4]);
			else if (pat[5 * i] == 32'h3)
				exp_wb.push_back(pat[5 * i + 1]);
			i++;
		end
		forever begin
			@(posedge clk);
			if (!rst) begin
				////////////////////////////// cpu requests
				if (req_valid && req_ready) begin
					line_addr = {req.addr[31:5], 5'd0}; // refill target on a miss.
					if (req.write) begin
						for (int b = 0; b < 4; b++) begin
							if (req.wstrb[b])
								ref_mem[req.addr[11:2]][b * 8 +: 8] = req.wdata[b * 8 +: 8];
						end
					end
				end
				////////////////////////////// cpu responses
				if (rsp_valid && rsp_ready) begin
					if (exp_rd.size() == 0) begin
						raise_error("read response arrived with no read pending");
					end else begin
						exp = exp_rd.pop_front();
						if (rsp_data !== exp)
							log_mismatch($sformatf("read data %h, expected %h", rsp_data, exp));
					end
				end
				////////////////////////////// memory side
				if (rd_req_valid && rd_req_ready) begin
					if (rd_req_addr !== line_addr || rd_req_len != 8'd7)
						log_mismatch($sformatf("refill addr %h len %0d, expected %h",
							rd_req_addr, rd_req_len, line_addr));
				end
				if (wr_req_valid && wr_req_ready) begin
					wb_beat = 0;
					wb_base = int'(wr_req_addr[11:2]);
					if (exp_wb.size() == 0) begin
						raise_error($sformatf("unexpected write-back to %h", wr_req_addr));
					end else begin
						exp_addr = exp_wb.pop_front();
						if (wr_req_addr !== exp_addr || wr_req_len != 8'd7)
							log_mismatch($sformatf("write-back addr %h, expected %h",
								wr_req_addr, exp_addr));
					end
				end
				if (wr_data_valid && wr_data_ready) begin
					if (wr_data !== ref_mem[wb_base + wb_beat])
						log_mismatch($sformatf("write-back beat %0d data %h, expected %h",
							wb_beat, wr_data, ref_mem[wb_base + wb_beat]));
					if (wr_data_strb != 4'b1111)
						log_mismatch($sformatf("write-back strobe %b", wr_data_strb));
					if (wr_data_last !== (wb_beat == 7)) // last on the eighth beat only.
						log_mismatch($sformatf("last flag wrong on beat %0d", wb_beat));
					wb_beat++;
				end
				if (drain && !drained) begin
					drained = 1'b1;
					if (exp_rd.size() != 0)
						raise_error($sformatf("%0d reads never answered", exp_rd.size()));
					if (exp_wb.size() != 0)
						raise_error($sformatf("%0d write-backs never seen", exp_wb.size()));
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/dcache_patterns.txt
// columns: op addr wdata wstrb expected, all hex
// op 1 read, 2 write, 3 expected write-back line address (in addr), f ends the list
// set 0 holds tags 1..5, set 1 holds tags 0..4
1 00000104 00000000 0 5a5a0041
2 00000104 deadbeef 3 00000000
1 00000104 00000000 0 5a5abeef
2 00000208 11223344 c 00000000
1 00000208 00000000 0 11220082
2 0000030c aabbccdd f 00000000
2 00000410 000000ff 1 00000000
1 00000104 00000000 0 5a5abeef
// fifth tag in set 0 pushes out the line at 0x200
3 00000200 00000000 0 00000000
1 00000500 00000000 0 5a5a0140
3 00000300 00000000 0 00000000
1 00000208 00000000 0 11220082
3 00000400 00000000 0 00000000
1 0000030c 00000000 0 aabbccdd
// clean lines in set 1, no write-back allowed
1 00000020 00000000 0 5a5a0008
1 00000120 00000000 0 5a5a0048
1 00000220 00000000 0 5a5a0088
1 00000320 00000000 0 5a5a00c8
1 00000420 00000000 0 5a5a0108
1 00000020 00000000 0 5a5a0008
1 00000420 00000000 0 5a5a0108
f 00000000 00000000 0 00000000

//--- tests/dcache_tb.sv
`default_nettype none

module dcache_tb;
	import dcache_pkg::*;

	localparam int PAT_WORDS = 320;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic req_valid = 1'b0;
	cpu_req_t req = '0;
	logic req_ready;
	logic rsp_valid;
	word_t rsp_data;
	logic rsp_ready = 1'b1;
	logic rd_req_valid;
	logic [31:0] rd_req_addr;
	logic [7:0] rd_req_len;
	logic rd_req_ready = 1'b0;
	logic rd_rsp_valid = 1'b0;
	word_t rd_rsp_data = '0;
	logic rd_rsp_last = 1'b0;
	logic rd_rsp_ready;
	logic wr_req_valid;
	logic [31:0] wr_req_addr;
	logic [7:0] wr_req_len;
	logic wr_req_ready = 1'b0;
	logic wr_data_valid;
	word_t wr_data;
	strb_t wr_data_strb;
	logic wr_data_last;
	logic wr_data_ready = 1'b0;
	logic drain = 1'b0;
	int err_count;
	int n_lines = 0;
	logic [31:0] pat [PAT_WORDS];

	always #2 clk = ~clk; // period 4.

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	dcache_top u_dcache_top (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
		.rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr), .rd_req_len(rd_req_len),
		.rd_req_ready(rd_req_ready), .rd_rsp_valid(rd_rsp_valid), .rd_rsp_data(rd_rsp_data),
		.rd_rsp_last(rd_rsp_last), .rd_rsp_ready(rd_rsp_ready),
		.wr_req_valid(wr_req_valid), .wr_req_addr(wr_req_addr), .wr_req_len(wr_req_len),
		.wr_req_ready(wr_req_ready), .wr_data_valid(wr_data_valid), .wr_data(wr_data),
		.wr_data_strb(wr_data_strb), .wr_data_last(wr_data_last), .wr_data_ready(wr_data_ready)
	);

	dcache_monitor u_monitor (
		.clk(clk), .rst(rst), .drain(drain),
		.req_valid(req_valid), .req_ready(req_ready), .req(req),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.rd_req_valid(rd_req_valid), .rd_req_ready(rd_req_ready),
		.rd_req_addr(rd_req_addr), .rd_req_len(rd_req_len),
		.wr_req_valid(wr_req_valid), .wr_req_ready(wr_req_ready),
		.wr_req_addr(wr_req_addr), .wr_req_len(wr_req_len),
		.wr_data_valid(wr_data_valid), .wr_data_ready(wr_data_ready), .wr_data(wr_data),
		.wr_data_strb(wr_data_strb), .wr_data_last(wr_data_last),
		.err_count(err_count)
	);

	// one request, called and left on a falling edge.
	task automatic send_request(input logic write, input logic [31:0] addr,
		input word_t wdata, input strb_t wstrb);
		req_valid = 1'b1;
		req.write = write;
		req.addr = addr;
		req.wdata = wdata;
		req.wstrb = wstrb;
		while (!req_ready)
			@(negedge clk); // ready only moves on rising edges.
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	////////////////////////////// memory model
	// decides at the falling edge what transfers at the next rising edge.
	initial begin : memory_model
		logic [31:0] mem [1024];
		logic [31:0] rng;
		logic rd_busy;
		logic wr_busy;
		logic go_rd;
		logic go_wr;
		int rd_base;
		int wr_base;
		int rd_beat;
		int wr_beat;
		rng = 32'h86ca;
		rd_busy = 1'b0;
		wr_busy = 1'b0;
		rd_base = 0;
		wr_base = 0;
		rd_beat = 0;
		wr_beat = 0;
		for (int i = 0; i < 1024; i++)
			mem[i] = i ^ 32'h5a5a0000; // word address mixed with a marker.
		forever begin
			@(negedge clk);
			rng = next_random(rng);
			go_rd = (rng[1:0] != 2'b00); // about one stall in four.
			go_wr = (rng[3:2] != 2'b00);
			rsp_ready = (rng[6:4] != 3'b000); // cpu side back-pressure.
			rd_req_ready = 1'b0;
			rd_rsp_valid = 1'b0;
			rd_rsp_last = 1'b0;
			if (rd_busy) begin
				rd_rsp_valid = go_rd;
				rd_rsp_data = mem[rd_base + rd_beat];
				rd_rsp_last = (rd_beat == 7);
				if (go_rd && rd_rsp_ready) begin
					rd_beat++;
					if (rd_beat == 8)
						rd_busy = 1'b0;
				end
			end else if (rd_req_valid && go_rd) begin
				rd_req_ready = 1'b1;
				rd_busy = 1'b1;
				rd_base = int'(rd_req_addr[11:2]);
				rd_beat = 0;
			end
			wr_req_ready = 1'b0;
			wr_data_ready = 1'b0;
			if (wr_busy) begin
				wr_data_ready = go_wr;
				if (go_wr && wr_data_valid) begin
					mem[wr_base + wr_beat] = wr_data; // victim word lands in memory.
					wr_beat++;
					if (wr_beat == 8)
						wr_busy = 1'b0;
				end
			end else if (wr_req_valid && go_wr) begin
				wr_req_ready = 1'b1;
				wr_busy = 1'b1;
				wr_base = int'(wr_req_addr[11:2]);
				wr_beat = 0;
			end
		end
	end

	////////////////////////////// cpu driver
	initial begin : cpu_driver
		logic [31:0] op;
		$readmemh("tests/dcache_patterns.txt", pat);
		while (n_lines < PAT_WORDS / 5 && pat[5 * n_lines] != 32'hf)
			n_lines++;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_lines; i++) begin
			op = pat[5 * i];
			if (op == 32'h1 || op == 32'h2) // write-back lines are for the monitor.
				send_request(op == 32'h2, pat[5 * i + 1], pat[5 * i + 2], pat[5 * i + 3][3:0]);
		end
		while (!req_ready)
			@(negedge clk); // last miss or response still open.
		drain = 1'b1;
		repeat (2) @(negedge clk);
		$display("errors: %0d", err_count);
		if (err_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	////////////////////////////// watchdog
	initial begin : watchdog
		wait (!rst);
		repeat (n_lines * 400) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", n_lines * 400);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
